/* filelist.f */
common/fft_stage_pkg.sv
hdl/shift_reg.sv
butterfly/twiddle_rom.sv
butterfly/butterfly.sv
hdl/fft_stage.sv
verification/clk_gen.sv
verification/fft_stage_tb.sv

/* Makefile */
SRCS := $(shell cat filelist.f)

obj_dir/Vfft_stage_tb: filelist.f $(SRCS)
	verilator --binary --timing --top-module fft_stage_tb --Mdir obj_dir -f filelist.f

.PHONY: run clean

run: obj_dir/Vfft_stage_tb
	./obj_dir/Vfft_stage_tb > sim.log 2>&1; cat sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/fft_stage_tb.sv */
`timescale 1ns/1ps

module fft_stage_tb;

    localparam int DW           = 9;
    localparam int SIZE         = 4;
    localparam int IN_SIZE      = 4;
    localparam int OW           = DW + 1;
    localparam int FRAME        = 2 * SIZE;
    localparam int N_FFT        = FRAME * IN_SIZE;
    localparam int FRAC         = 8;
    localparam int MAX_BLOCKS   = 256;
    localparam int TOTAL_BLOCKS = 26 * SIZE;  // all five tests
    localparam int TIMEOUT      = 20 * TOTAL_BLOCKS + 100;
    localparam int MAXV         = (1 << (DW - 1)) - 1;
    localparam int MINV         = -(1 << (DW - 1));

    logic                 clk;
    logic                 rstn;
    logic                 din_valid;
    logic signed [DW-1:0] din_i [0:IN_SIZE-1];
    logic signed [DW-1:0] din_q [0:IN_SIZE-1];
    logic                 dout_valid;
    logic signed [OW-1:0] sum_i [0:IN_SIZE-1];
    logic signed [OW-1:0] sum_q [0:IN_SIZE-1];
    logic signed [OW-1:0] diff_i [0:IN_SIZE-1];
    logic signed [OW-1:0] diff_q [0:IN_SIZE-1];

    int sent_i [0:MAX_BLOCKS-1][0:IN_SIZE-1];  // history of accepted blocks
    int sent_q [0:MAX_BLOCKS-1][0:IN_SIZE-1];
    int blk_i [0:IN_SIZE-1];                   // next block to drive
    int blk_q [0:IN_SIZE-1];
    logic signed [OW-1:0] obs_diff_i [0:MAX_BLOCKS-1][0:IN_SIZE-1];
    logic signed [OW-1:0] obs_diff_q [0:MAX_BLOCKS-1][0:IN_SIZE-1];

    int exp_block [$];
    int exp_due [$];  // cycle the output should appear
    int exp_sum_i [$];
    int exp_sum_q [$];
    int exp_diff_i [$];
    int exp_diff_q [$];

    int n_sent   = 0;
    int n_out    = 0;
    int n_checks = 0;
    int n_errors = 0;
    int cycles   = 0;

    clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) u_clk_gen (.clk_o(clk), .rstn_o(rstn));

    fft_stage #(.DATA_WIDTH(DW), .SIZE(SIZE), .IN_SIZE(IN_SIZE)) dut0 (
        .clk          (clk),
        .rstn         (rstn),
        .din_valid_i  (din_valid),
        .din_i_i      (din_i),
        .din_q_i      (din_q),
        .dout_valid_o (dout_valid),
        .sum_i_o      (sum_i),
        .sum_q_o      (sum_q),
        .diff_i_o     (diff_i),
        .diff_q_o     (diff_q)
    );

    // half away from zero
    function automatic int round_coef(input real v);
        real s;
        s = v * real'(1 << FRAC);
        if (s >= 0.0) begin
            return $rtoi($floor(s + 0.5));
        end
        return -$rtoi($floor(0.5 - s));
    endfunction

    function automatic int wrap_out(input int v);
        logic signed [OW-1:0] t;
        t = v[OW-1:0];
        return int'(t);
    endfunction

    // expected lane result for accepted block n
    function automatic void ref_lane(input int n, input int l, output int s_i, output int s_q,
                                     output int d_i, output int d_q);
        int  k;
        int  wr;
        int  wi;
        int  dr;
        int  dq;
        real ang;
        k   = ((n % FRAME) - SIZE) * IN_SIZE + l;
        ang = 6.283185307179586 * real'(k) / real'(N_FFT);
        wr  = round_coef($cos(ang));
        wi  = round_coef(-$sin(ang));
        dr  = sent_i[n-SIZE][l] - sent_i[n][l];
        dq  = sent_q[n-SIZE][l] - sent_q[n][l];
        s_i = sent_i[n-SIZE][l] + sent_i[n][l];
        s_q = sent_q[n-SIZE][l] + sent_q[n][l];
        d_i = wrap_out((dr * wr - dq * wi) >>> FRAC);
        d_q = wrap_out((dr * wi + dq * wr) >>> FRAC);
    endfunction

    task automatic send_block(input logic valid);
        int s_i;
        int s_q;
        int d_i;
        int d_q;
        @(negedge clk);
        din_valid = valid;
        for (int l = 0; l < IN_SIZE; l++) begin
            din_i[l] = DW'(blk_i[l]);
            din_q[l] = DW'(blk_q[l]);
        end
        if (valid) begin
            for (int l = 0; l < IN_SIZE; l++) begin
                sent_i[n_sent][l] = blk_i[l];
                sent_q[n_sent][l] = blk_q[l];
            end
            if (n_sent % FRAME >= SIZE) begin
                exp_block.push_back(n_sent);
                exp_due.push_back(cycles + 2);
                for (int l = 0; l < IN_SIZE; l++) begin
                    ref_lane(n_sent, l, s_i, s_q, d_i, d_q);
                    exp_sum_i.push_back(s_i);
                    exp_sum_q.push_back(s_q);
                    exp_diff_i.push_back(d_i);
                    exp_diff_q.push_back(d_q);
                end
            end
            n_sent++;
        end
    endtask

    task automatic fill_random();
        for (int l = 0; l < IN_SIZE; l++) begin
            blk_i[l] = int'($urandom_range(0, (1 << DW) - 1)) + MINV;
            blk_q[l] = int'($urandom_range(0, (1 << DW) - 1)) + MINV;
        end
    endtask

    task automatic send_frame(input int fi, input int fq, input int pi, input int pq);
        for (int b = 0; b < FRAME; b++) begin
            for (int l = 0; l < IN_SIZE; l++) begin
                blk_i[l] = (b < SIZE) ? fi : pi;
                blk_q[l] = (b < SIZE) ? fq : pq;
            end
            send_block(1'b1);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        din_valid = 1'b0;
        while (exp_block.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_block.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_block.size());
            n_errors++;
            exp_block.delete();
            exp_due.delete();
            exp_sum_i.delete();
            exp_sum_q.delete();
            exp_diff_i.delete();
            exp_diff_q.delete();
        end
        repeat (3) @(negedge clk);  // let any stray output show up
    endtask

    task automatic compare(input string name, input int n, input int l, input int expv,
                           input logic signed [OW-1:0] got);
        logic [OW-1:0] e;
        e = OW'(expv);
        n_checks++;
        if (e !== got) begin
            $display("FAIL %s block %0d lane %0d: expected %h, got %h", name, n, l, e, got);
            n_errors++;
        end
    endtask

    task automatic check_output();
        int n;
        int due;
        n   = exp_block.pop_front();
        due = exp_due.pop_front();
        if (cycles != due) begin
            $display("block %0d came out at cycle %0d instead of %0d", n, cycles, due);
            n_errors++;
        end
        for (int l = 0; l < IN_SIZE; l++) begin
            compare("sum_i_o", n, l, exp_sum_i.pop_front(), sum_i[l]);
            compare("sum_q_o", n, l, exp_sum_q.pop_front(), sum_q[l]);
            compare("diff_i_o", n, l, exp_diff_i.pop_front(), diff_i[l]);
            compare("diff_q_o", n, l, exp_diff_q.pop_front(), diff_q[l]);
            obs_diff_i[n_out][l] = diff_i[l];
            obs_diff_q[n_out][l] = diff_q[l];
        end
    endtask

    always @(negedge clk) begin
        if (rstn && dout_valid) begin
            if (exp_block.size() == 0) begin
                $display("dout_valid_o high with no paired block pending");
                n_errors++;
            end else begin
                check_output();
            end
            n_out++;
        end
    end

    task automatic print_result(input string name, input int errs_before);
        $display("test %s: %0d errors", name, n_errors - errs_before);
    endtask

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int err0;
        int accepted;
        int base;
        int kq;
        void'($urandom(32'h2caf_be6e));
        din_valid = 1'b0;
        for (int l = 0; l < IN_SIZE; l++) begin
            din_i[l] = '0;
            din_q[l] = '0;
        end

        // reset is released on a falling edge, so look on the rising one
        err0 = n_errors;
        @(posedge clk);
        while (rstn !== 1'b1) begin
            n_checks++;
            if (dout_valid !== 1'b0) begin
                $display("dout_valid_o not low during reset");
                n_errors++;
            end
            @(posedge clk);
        end
        for (int b = 0; b < SIZE; b++) begin
            fill_random();
            send_block(1'b1);
        end
        drain();
        n_checks++;
        if (n_out != 0) begin
            $display("outputs appeared during the first fill half");
            n_errors++;
        end
        print_result("1 reset and fill", err0);

        err0 = n_errors;
        for (int b = 0; b < 4 * FRAME; b++) begin
            fill_random();
            send_block(1'b1);
        end
        drain();
        print_result("2 back-to-back stream", err0);

        err0 = n_errors;
        accepted = 0;
        while (accepted < 4 * FRAME) begin
            fill_random();
            if ($urandom_range(0, 2) == 0) begin
                send_block(1'b0);  // gap, data ignored
            end else begin
                send_block(1'b1);
                accepted++;
            end
        end
        drain();
        print_result("3 gapped stream", err0);

        // diff of 1.0 in fixed point exposes each coefficient
        err0 = n_errors;
        while (n_sent % FRAME != 0) begin
            fill_random();
            send_block(1'b1);
        end
        send_frame((1 << FRAC) - 1, 0, -1, 0);
        drain();
        base = n_out - SIZE;
        kq   = N_FFT / 4;
        compare("diff_i_o", n_sent - SIZE, 0, 1 << FRAC, obs_diff_i[base][0]);
        compare("diff_q_o", n_sent - SIZE, 0, 0, obs_diff_q[base][0]);
        compare("diff_i_o", n_sent - SIZE + kq / IN_SIZE, kq % IN_SIZE, 0,
                obs_diff_i[base + kq / IN_SIZE][kq % IN_SIZE]);
        compare("diff_q_o", n_sent - SIZE + kq / IN_SIZE, kq % IN_SIZE, -(1 << FRAC),
                obs_diff_q[base + kq / IN_SIZE][kq % IN_SIZE]);
        print_result("4 twiddle corners", err0);

        err0 = n_errors;
        send_frame(MAXV, MINV, MAXV, MINV);
        send_frame(MAXV, MAXV, MINV, MINV);
        send_frame(MINV, MAXV, MAXV, MINV);
        drain();
        print_result("5 extreme values", err0);

        $display("checks %0d, errors %0d, blocks %0d, outputs %0d",
                 n_checks, n_errors, n_sent, n_out);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // release away from the rising edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

/* hdl/fft_stage.sv */
`timescale 1ns/1ps

module fft_stage import fft_stage_pkg::*; #(
    parameter int DATA_WIDTH = 9,
    parameter int SIZE       = 4,
    parameter int IN_SIZE    = 4
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         din_valid_i,
    input  logic signed [DATA_WIDTH-1:0] din_i_i [0:IN_SIZE-1],
    input  logic signed [DATA_WIDTH-1:0] din_q_i [0:IN_SIZE-1],
    output logic                         dout_valid_o,
    output logic signed [DATA_WIDTH:0]   sum_i_o [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH:0]   sum_q_o [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH:0]   diff_i_o [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH:0]   diff_q_o [0:IN_SIZE-1]
);

    logic signed [DATA_WIDTH-1:0] front_i [0:IN_SIZE-1];
    logic signed [DATA_WIDTH-1:0] front_q [0:IN_SIZE-1];
    frame_phase_e                 phase;
    logic [$clog2(SIZE)-1:0]      pair_index;
    logic                         bufly_enable;

    logic signed [COEF_WIDTH-1:0] w_re   [0:IN_SIZE-1];  // rom, acceptance cycle
    logic signed [COEF_WIDTH-1:0] w_im   [0:IN_SIZE-1];
    logic signed [COEF_WIDTH-1:0] w_re_q [0:IN_SIZE-1];  // lined up with stage 2
    logic signed [COEF_WIDTH-1:0] w_im_q [0:IN_SIZE-1];

    shift_reg #(
        .DATA_WIDTH (DATA_WIDTH),
        .SIZE       (SIZE),
        .IN_SIZE    (IN_SIZE)
    ) u_shift_reg (
        .clk            (clk),
        .rstn           (rstn),
        .din_valid_i    (din_valid_i),
        .din_i_i        (din_i_i),
        .din_q_i        (din_q_i),
        .front_i_o      (front_i),
        .front_q_o      (front_q),
        .phase_o        (phase),
        .pair_index_o   (pair_index),
        .bufly_enable_o (bufly_enable)
    );

    twiddle_rom #(
        .SIZE    (SIZE),
        .IN_SIZE (IN_SIZE)
    ) u_twiddle_rom (
        .pair_index_i (pair_index),
        .w_re_o       (w_re),
        .w_im_o       (w_im)
    );

    // one cycle delay so coefficients meet the stage-1 differences
    always_ff @(posedge clk) begin
        w_re_q <= w_re;
        w_im_q <= w_im;
    end

    butterfly #(
        .DATA_WIDTH (DATA_WIDTH),
        .IN_SIZE    (IN_SIZE)
    ) u_butterfly (
        .clk          (clk),
        .rstn         (rstn),
        .enable_i     (bufly_enable),
        .phase_i      (phase),
        .a_i_i        (front_i),
        .a_q_i        (front_q),
        .b_i_i        (din_i_i),
        .b_q_i        (din_q_i),
        .w_re_i       (w_re_q),
        .w_im_i       (w_im_q),
        .dout_valid_o (dout_valid_o),
        .sum_i_o      (sum_i_o),
        .sum_q_o      (sum_q_o),
        .diff_i_o     (diff_i_o),
        .diff_q_o     (diff_q_o)
    );

endmodule

/* butterfly/butterfly.sv */
`timescale 1ns/1ps

module butterfly import fft_stage_pkg::*; #(
    parameter int DATA_WIDTH = 9,
    parameter int IN_SIZE    = 4
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         enable_i,
    input  frame_phase_e                 phase_i,
    input  logic signed [DATA_WIDTH-1:0] a_i_i [0:IN_SIZE-1],  // front block
    input  logic signed [DATA_WIDTH-1:0] a_q_i [0:IN_SIZE-1],
    input  logic signed [DATA_WIDTH-1:0] b_i_i [0:IN_SIZE-1],  // current block
    input  logic signed [DATA_WIDTH-1:0] b_q_i [0:IN_SIZE-1],
    input  logic signed [COEF_WIDTH-1:0] w_re_i [0:IN_SIZE-1],  // aligned to stage 2
    input  logic signed [COEF_WIDTH-1:0] w_im_i [0:IN_SIZE-1],
    output logic                         dout_valid_o,
    output logic signed [DATA_WIDTH:0]   sum_i_o [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH:0]   sum_q_o [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH:0]   diff_i_o [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH:0]   diff_q_o [0:IN_SIZE-1]
);

    localparam int OUT_W  = DATA_WIDTH + 1;
    localparam int PROD_W = OUT_W + COEF_WIDTH + 1;  // room for the partial sum

    logic take_pair;
    logic s1_valid;

    logic signed [OUT_W-1:0]  s1_sum_i  [0:IN_SIZE-1];
    logic signed [OUT_W-1:0]  s1_sum_q  [0:IN_SIZE-1];
    logic signed [OUT_W-1:0]  s1_diff_i [0:IN_SIZE-1];
    logic signed [OUT_W-1:0]  s1_diff_q [0:IN_SIZE-1];
    logic signed [PROD_W-1:0] prod_re   [0:IN_SIZE-1];
    logic signed [PROD_W-1:0] prod_im   [0:IN_SIZE-1];
    logic signed [PROD_W-1:0] rot_re    [0:IN_SIZE-1];
    logic signed [PROD_W-1:0] rot_im    [0:IN_SIZE-1];

    assign take_pair = enable_i && (phase_i == PH_PAIR);

    // valid travels with the data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid     <= 1'b0;
            dout_valid_o <= 1'b0;
        end else begin
            s1_valid     <= take_pair;
            dout_valid_o <= s1_valid;
        end
    end

    // stage 1: lane sums and differences, one bit of growth
    always_ff @(posedge clk) begin
        if (take_pair) begin
            for (int l = 0; l < IN_SIZE; l++) begin
                s1_sum_i[l]  <= OUT_W'(a_i_i[l]) + OUT_W'(b_i_i[l]);
                s1_sum_q[l]  <= OUT_W'(a_q_i[l]) + OUT_W'(b_q_i[l]);
                s1_diff_i[l] <= OUT_W'(a_i_i[l]) - OUT_W'(b_i_i[l]);
                s1_diff_q[l] <= OUT_W'(a_q_i[l]) - OUT_W'(b_q_i[l]);
            end
        end
    end

    // (dr + j*dq) * (wr + j*wi), full precision then drop the fraction
    always_comb begin
        for (int l = 0; l < IN_SIZE; l++) begin
            prod_re[l] = PROD_W'(s1_diff_i[l]) * PROD_W'(w_re_i[l])
                       - PROD_W'(s1_diff_q[l]) * PROD_W'(w_im_i[l]);
            prod_im[l] = PROD_W'(s1_diff_i[l]) * PROD_W'(w_im_i[l])
                       + PROD_W'(s1_diff_q[l]) * PROD_W'(w_re_i[l]);
            rot_re[l]  = prod_re[l] >>> COEF_FRAC;
            rot_im[l]  = prod_im[l] >>> COEF_FRAC;
        end
    end

    // stage 2: rotated diff plus delayed sum
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int l = 0; l < IN_SIZE; l++) begin
                sum_i_o[l]  <= s1_sum_i[l];
                sum_q_o[l]  <= s1_sum_q[l];
                diff_i_o[l] <= rot_re[l][OUT_W-1:0];  // keep DATA_WIDTH+1 bits
                diff_q_o[l] <= rot_im[l][OUT_W-1:0];
            end
        end
    end

endmodule

/* butterfly/twiddle_rom.sv */
`timescale 1ns/1ps

module twiddle_rom import fft_stage_pkg::*; #(
    parameter int SIZE    = 4,
    parameter int IN_SIZE = 4
) (
    input  logic [$clog2(SIZE)-1:0]      pair_index_i,
    output logic signed [COEF_WIDTH-1:0] w_re_o [0:IN_SIZE-1],
    output logic signed [COEF_WIDTH-1:0] w_im_o [0:IN_SIZE-1]
);

    localparam int DEPTH  = SIZE * IN_SIZE;  // one entry per paired sample
    localparam int N_FFT  = 2 * DEPTH;
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic signed [COEF_WIDTH-1:0] rom_re [0:DEPTH-1];
    logic signed [COEF_WIDTH-1:0] rom_im [0:DEPTH-1];

    // W(k) = exp(-j*2*pi*k/N), so im part is -sin
    initial begin
        real angle;
        for (int k = 0; k < DEPTH; k++) begin
            angle     = TWO_PI * real'(k) / real'(N_FFT);
            rom_re[k] = coef_round($cos(angle));
            rom_im[k] = coef_round(-$sin(angle));
        end
    end

    // lane l of pair position p reads entry p*IN_SIZE + l
    for (genvar l = 0; l < IN_SIZE; l++) begin : g_lane
        logic [ADDR_W-1:0] addr;

        assign addr      = ADDR_W'(pair_index_i * IN_SIZE + l);
        assign w_re_o[l] = rom_re[addr];
        assign w_im_o[l] = rom_im[addr];
    end

endmodule

/* hdl/shift_reg.sv */
`timescale 1ns/1ps

module shift_reg import fft_stage_pkg::*; #(
    parameter int DATA_WIDTH = 9,
    parameter int SIZE       = 4,
    parameter int IN_SIZE    = 4
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         din_valid_i,
    input  logic signed [DATA_WIDTH-1:0] din_i_i [0:IN_SIZE-1],
    input  logic signed [DATA_WIDTH-1:0] din_q_i [0:IN_SIZE-1],
    output logic signed [DATA_WIDTH-1:0] front_i_o [0:IN_SIZE-1],  // oldest block
    output logic signed [DATA_WIDTH-1:0] front_q_o [0:IN_SIZE-1],
    output frame_phase_e                 phase_o,
    output logic [$clog2(SIZE)-1:0]      pair_index_o,
    output logic                         bufly_enable_o
);

    localparam int CNT_W = $clog2(2 * SIZE);
    localparam int IDX_W = $clog2(SIZE);
    localparam logic [CNT_W-1:0] LAST_POS = CNT_W'(2 * SIZE - 1);
    localparam logic [CNT_W-1:0] HALF_POS = CNT_W'(SIZE);

    // delay line of SIZE blocks, entry 0 is the front
    logic signed [DATA_WIDTH-1:0] buf_i [0:SIZE-1][0:IN_SIZE-1];
    logic signed [DATA_WIDTH-1:0] buf_q [0:SIZE-1][0:IN_SIZE-1];

    logic [CNT_W-1:0] frame_pos;  // accepted blocks mod 2*SIZE
    logic [CNT_W-1:0] pair_pos;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < SIZE; i++) begin
                for (int j = 0; j < IN_SIZE; j++) begin
                    buf_i[i][j] <= '0;
                    buf_q[i][j] <= '0;
                end
            end
        end else if (din_valid_i) begin
            for (int i = 0; i < SIZE - 1; i++) begin
                buf_i[i] <= buf_i[i+1];  // move toward the front
                buf_q[i] <= buf_q[i+1];
            end
            buf_i[SIZE-1] <= din_i_i;    // new block at the tail
            buf_q[SIZE-1] <= din_q_i;
        end
    end

    // frame position, wraps instead of saturating
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_pos <= '0;
        end else if (din_valid_i) begin
            if (frame_pos == LAST_POS) begin
                frame_pos <= '0;
            end else begin
                frame_pos <= frame_pos + 1'b1;
            end
        end
    end

    assign phase_o  = (frame_pos >= HALF_POS) ? PH_PAIR : PH_FILL;
    assign pair_pos = frame_pos - HALF_POS;  // only meaningful in PH_PAIR

    assign pair_index_o   = pair_pos[IDX_W-1:0];
    assign bufly_enable_o = din_valid_i && (phase_o == PH_PAIR);

    assign front_i_o = buf_i[0];
    assign front_q_o = buf_q[0];

endmodule

/* common/fft_stage_pkg.sv */
package fft_stage_pkg;

    localparam int COEF_WIDTH = 10;  // signed twiddle component
    localparam int COEF_FRAC  = 8;   // 1.0 stored as 256

    localparam real COEF_SCALE = real'(1 << COEF_FRAC);
    localparam real TWO_PI     = 6.283185307179586;

    // which half of the 2*SIZE block frame we are in
    typedef enum logic {
        PH_FILL = 1'b0,
        PH_PAIR = 1'b1
    } frame_phase_e;

    // scale to fixed point, round half away from zero
    function automatic logic signed [COEF_WIDTH-1:0] coef_round(input real value);
        real scaled;
        int  mag;
        scaled = value * COEF_SCALE;
        if (scaled >= 0.0) begin
            mag = $rtoi(scaled + 0.5);
            return COEF_WIDTH'(mag);
        end
        mag = $rtoi(0.5 - scaled);
        return COEF_WIDTH'(-mag);
    endfunction

endpackage
